//--- verilog/rv_isa_pkg.sv
/*
 * ISA-level definitions for the RV32I execute stage:
 * data word width, ALU opcodes, branch compare codes, memory access widths
 */

package rv_isa_pkg;

    // default data word width
    parameter int XLEN = 32;

    // ALU operation select
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_R = 4'd10
    } alu_op_e;

    // branch compare, encoded as funct3
    typedef enum logic [2:0] {
        CMP_BEQ  = 3'b000,
        CMP_BNE  = 3'b001,
        CMP_BLT  = 3'b100,
        CMP_BGE  = 3'b101,
        CMP_BLTU = 3'b110,
        CMP_BGEU = 3'b111
    } cmp_op_e;

    // load/store width, funct3[1:0]
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_width_e;

endpackage

//--- verilog/ex_stage_pkg.sv
/*
 * Pipeline-level definitions for the execute stage:
 * result destination zones and trap cause codes
 */

package ex_stage_pkg;

    // where the result of an instruction goes
    typedef enum logic [1:0] {
        ZONE_NONE    = 2'd0,
        ZONE_REGFILE = 2'd1,
        ZONE_LOADQ   = 2'd2,
        ZONE_STOREQ  = 2'd3
    } zone_e;

    // trap cause, mcause exception codes
    typedef enum logic [3:0] {
        CAUSE_INS_MISALIGNED   = 4'd0,
        CAUSE_LOAD_MISALIGNED  = 4'd4,
        CAUSE_STORE_MISALIGNED = 4'd6,
        CAUSE_NONE             = 4'd15
    } trap_cause_e;

endpackage

//--- verilog/ex_operand_reg.sv
/*
 * Execute stage input register: captures the decoded instruction fields,
 * decodes the result zone into write flags and computes the return address
 */

`timescale 1ns/1ns

module ex_operand_reg #(
    parameter int XLEN = rv_isa_pkg::XLEN
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      stage_en_i,
    // decoded instruction
    input  logic                      valid_i,
    input  logic                      jump_i,
    input  logic                      cond_i,
    input  logic                      link_i,
    input  ex_stage_pkg::zone_e       zone_i,
    input  logic [1:0]                ins_size_i,
    input  logic [XLEN-1:0]           pc_i,
    input  logic [XLEN-1:0]           regs2_data_i,
    input  logic [4:0]                regd_addr_i,
    input  logic [2:0]                funct3_i,
    // registered instruction
    output logic                      valid_o,
    output logic                      jump_o,
    output logic                      cond_o,
    output logic                      link_o,
    output logic                      lq_wr_o,
    output logic                      sq_wr_o,
    output logic                      regd_wr_o,
    output logic [XLEN-1:0]           pc_inc_o,
    output logic [XLEN-1:0]           regs2_data_o,
    output logic [4:0]                regd_addr_o,
    output logic [2:0]                funct3_o
);

    // funct3 kept as unsigned flag plus access width
    logic                   unsigned_q;
    rv_isa_pkg::mem_width_e width_q;

    //----------------------------------------------------------------------
    // valid flag
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else if (stage_en_i) begin
            valid_o <= valid_i;
        end
    end

    //----------------------------------------------------------------------
    // instruction fields
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (stage_en_i) begin
            jump_o       <= jump_i;
            cond_o       <= cond_i;
            link_o       <= link_i;
            // one-hot zone flags
            lq_wr_o      <= (zone_i == ex_stage_pkg::ZONE_LOADQ);
            sq_wr_o      <= (zone_i == ex_stage_pkg::ZONE_STOREQ);
            regd_wr_o    <= (zone_i == ex_stage_pkg::ZONE_REGFILE);
            // return address, size counted in halfwords
            pc_inc_o     <= pc_i + {{(XLEN-3){1'b0}}, ins_size_i, 1'b0};
            regs2_data_o <= regs2_data_i;
            regd_addr_o  <= regd_addr_i;
            unsigned_q   <= funct3_i[2];
            width_q      <= rv_isa_pkg::mem_width_e'(funct3_i[1:0]);
        end
    end

    assign funct3_o = {unsigned_q, width_q};

endmodule

//--- verilog/ex_alu.sv
/*
 * Registered ALU and branch comparator
 */

`timescale 1ns/1ns

module ex_alu #(
    parameter int XLEN = rv_isa_pkg::XLEN
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 stage_en_i,
    // arithmetic
    input  rv_isa_pkg::alu_op_e  op_i,
    input  logic [XLEN-1:0]      left_i,
    input  logic [XLEN-1:0]      right_i,
    output logic [XLEN-1:0]      result_o,
    // branch compare
    input  rv_isa_pkg::cmp_op_e  cmp_op_i,
    input  logic [XLEN-1:0]      cmp_left_i,
    input  logic [XLEN-1:0]      cmp_right_i,
    output logic                 cmp_o
);

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0]  shamt;
    logic [XLEN-1:0] result;
    logic            cmp;

    assign shamt = right_i[SHW-1:0];

    //----------------------------------------------------------------------
    // operation select
    //----------------------------------------------------------------------
    always_comb begin
        case (op_i)
            rv_isa_pkg::ALU_ADD    : result = left_i + right_i;
            rv_isa_pkg::ALU_SUB    : result = left_i - right_i;
            rv_isa_pkg::ALU_SLL    : result = left_i << shamt;
            rv_isa_pkg::ALU_SLT    : result = {{(XLEN-1){1'b0}},
                                               $signed(left_i) < $signed(right_i)};
            rv_isa_pkg::ALU_SLTU   : result = {{(XLEN-1){1'b0}}, left_i < right_i};
            rv_isa_pkg::ALU_XOR    : result = left_i ^ right_i;
            rv_isa_pkg::ALU_SRL    : result = left_i >> shamt;
            rv_isa_pkg::ALU_SRA    : result = $unsigned($signed(left_i) >>> shamt);
            rv_isa_pkg::ALU_OR     : result = left_i | right_i;
            rv_isa_pkg::ALU_AND    : result = left_i & right_i;
            rv_isa_pkg::ALU_PASS_R : result = right_i;
            default                : result = '0;
        endcase
    end

    // branch relation, funct3 encoded
    always_comb begin
        case (cmp_op_i)
            rv_isa_pkg::CMP_BEQ  : cmp = (cmp_left_i == cmp_right_i);
            rv_isa_pkg::CMP_BNE  : cmp = (cmp_left_i != cmp_right_i);
            rv_isa_pkg::CMP_BLT  : cmp = ($signed(cmp_left_i) <  $signed(cmp_right_i));
            rv_isa_pkg::CMP_BGE  : cmp = ($signed(cmp_left_i) >= $signed(cmp_right_i));
            rv_isa_pkg::CMP_BLTU : cmp = (cmp_left_i <  cmp_right_i);
            rv_isa_pkg::CMP_BGEU : cmp = (cmp_left_i >= cmp_right_i);
            default              : cmp = 1'b0;
        endcase
    end

    //----------------------------------------------------------------------
    // output register, same enable as the operand register
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (stage_en_i) begin
            result_o <= result;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cmp_o <= 1'b0;
        end else if (stage_en_i) begin
            cmp_o <= cmp;
        end
    end

endmodule

//--- verilog/ex_commit_ctrl.sv
/*
 * Commit qualification, misalignment trap detection, stall control,
 * fetch redirect and write-back selection
 */

`timescale 1ns/1ns

module ex_commit_ctrl #(
    parameter int              XLEN        = rv_isa_pkg::XLEN,
    parameter logic [XLEN-1:0] TRAP_VECTOR = 32'h0000_0100
) (
    // registered instruction
    input  logic                       valid_i,
    input  logic                       jump_i,
    input  logic                       cond_i,
    input  logic                       link_i,
    input  logic                       lq_wr_i,
    input  logic                       sq_wr_i,
    input  logic                       regd_wr_i,
    input  logic [2:0]                 funct3_i,
    input  logic [XLEN-1:0]            pc_inc_i,
    input  logic [XLEN-1:0]            alu_result_i,
    input  logic                       cmp_i,
    // queue back-pressure
    input  logic                       lsq_full_i,
    // stage control
    output logic                       stage_en_o,
    output logic                       stall_o,
    // resolution strobes
    output logic                       regd_wr_o,
    output logic [XLEN-1:0]            regd_data_o,
    output logic                       jump_o,
    output logic [XLEN-1:0]            jump_addr_o,
    output logic                       lq_wr_o,
    output logic                       sq_wr_o,
    output logic                       trap_o,
    output ex_stage_pkg::trap_cause_e  trap_cause_o
);

    rv_isa_pkg::mem_width_e width;
    logic                   taken;
    logic                   addr_misaligned;
    logic                   excp_maif;
    logic                   excp_mala;
    logic                   excp_masa;
    logic                   trap;
    logic                   commit;

    //----------------------------------------------------------------------
    // misalignment detection
    //----------------------------------------------------------------------
    assign width = rv_isa_pkg::mem_width_e'(funct3_i[1:0]);
    assign taken = cmp_i | ~cond_i;

    always_comb begin
        case (width)
            rv_isa_pkg::MEM_HALF : addr_misaligned = alu_result_i[0];
            rv_isa_pkg::MEM_WORD : addr_misaligned = |alu_result_i[1:0];
            default              : addr_misaligned = 1'b0;
        endcase
    end

    // not-taken branches never fetch from the target
    assign excp_maif = jump_i & taken & alu_result_i[1];
    assign excp_mala = lq_wr_i & addr_misaligned;
    assign excp_masa = sq_wr_i & addr_misaligned;

    assign trap   = valid_i & (excp_maif | excp_mala | excp_masa);
    assign commit = valid_i & taken & ~trap;

    always_comb begin
        if (!trap) begin
            trap_cause_o = ex_stage_pkg::CAUSE_NONE;
        end else if (excp_maif) begin
            trap_cause_o = ex_stage_pkg::CAUSE_INS_MISALIGNED;
        end else if (excp_mala) begin
            trap_cause_o = ex_stage_pkg::CAUSE_LOAD_MISALIGNED;
        end else begin
            trap_cause_o = ex_stage_pkg::CAUSE_STORE_MISALIGNED;
        end
    end

    //----------------------------------------------------------------------
    // stall control
    //----------------------------------------------------------------------
    assign stall_o    = commit & lsq_full_i & (lq_wr_i | sq_wr_i);
    assign stage_en_o = ~stall_o;

    //----------------------------------------------------------------------
    // strobes, redirect and write-back
    //----------------------------------------------------------------------
    assign regd_wr_o = stage_en_o & commit & regd_wr_i;
    assign lq_wr_o   = stage_en_o & commit & lq_wr_i;
    assign sq_wr_o   = stage_en_o & commit & sq_wr_i;
    assign jump_o    = stage_en_o & ((commit & jump_i) | trap);
    assign trap_o    = stage_en_o & trap;

    assign jump_addr_o = trap ? TRAP_VECTOR : {alu_result_i[XLEN-1:1], 1'b0};
    assign regd_data_o = link_i ? pc_inc_i : alu_result_i;

endmodule

//--- verilog/ex_stage.sv
/*
 * Execute stage top level: operand register, ALU and commit control
 */

`timescale 1ns/1ns

module ex_stage #(
    parameter int              XLEN        = rv_isa_pkg::XLEN,
    parameter logic [XLEN-1:0] TRAP_VECTOR = 32'h0000_0100
) (
    input  logic                       clk_i,
    input  logic                       reset_i,
    // decode stage
    input  logic                       ids_valid_i,
    output logic                       ids_stall_o,
    input  logic [1:0]                 ids_ins_size_i,
    input  logic                       ids_jump_i,
    input  logic                       ids_cond_i,
    input  logic                       ids_link_i,
    input  ex_stage_pkg::zone_e        ids_zone_i,
    input  logic [XLEN-1:0]            ids_pc_i,
    input  rv_isa_pkg::alu_op_e        ids_alu_op_i,
    input  logic [XLEN-1:0]            ids_operand_left_i,
    input  logic [XLEN-1:0]            ids_operand_right_i,
    input  logic [XLEN-1:0]            ids_regs1_data_i,
    input  logic [XLEN-1:0]            ids_cmp_right_i,
    input  logic [XLEN-1:0]            ids_regs2_data_i,
    input  logic [2:0]                 ids_funct3_i,
    input  logic [4:0]                 ids_regd_addr_i,
    // register write-back
    output logic                       ids_regd_wr_o,
    output logic [4:0]                 ids_regd_addr_o,
    output logic [XLEN-1:0]            ids_regd_data_o,
    // fetch redirect
    output logic                       pfu_jump_o,
    output logic [XLEN-1:0]            pfu_jump_addr_o,
    // load/store queue
    input  logic                       lsq_full_i,
    output logic                       lsq_lq_wr_o,
    output logic                       lsq_sq_wr_o,
    output logic [2:0]                 lsq_funct3_o,
    output logic [4:0]                 lsq_regd_addr_o,
    output logic [XLEN-1:0]            lsq_regs2_data_o,
    output logic [XLEN-1:0]            lsq_addr_o,
    // trap report
    output logic                       trap_o,
    output ex_stage_pkg::trap_cause_e  trap_cause_o
);

    logic            stage_en;
    logic            ex_valid;
    logic            ex_jump;
    logic            ex_cond;
    logic            ex_link;
    logic            ex_lq_wr;
    logic            ex_sq_wr;
    logic            ex_regd_wr;
    logic [XLEN-1:0] ex_pc_inc;
    logic [4:0]      ex_regd_addr;
    logic [2:0]      ex_funct3;
    logic [XLEN-1:0] alu_result;
    logic            alu_cmp;

    // queue side fields come straight from the registers
    assign ids_regd_addr_o = ex_regd_addr;
    assign lsq_regd_addr_o = ex_regd_addr;
    assign lsq_funct3_o    = ex_funct3;
    assign lsq_addr_o      = alu_result;

    //----------------------------------------------------------------------
    // input register
    //----------------------------------------------------------------------
    ex_operand_reg #(
        .XLEN (XLEN)
    ) ex_operand_reg_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .stage_en_i   (stage_en),
        .valid_i      (ids_valid_i),
        .jump_i       (ids_jump_i),
        .cond_i       (ids_cond_i),
        .link_i       (ids_link_i),
        .zone_i       (ids_zone_i),
        .ins_size_i   (ids_ins_size_i),
        .pc_i         (ids_pc_i),
        .regs2_data_i (ids_regs2_data_i),
        .regd_addr_i  (ids_regd_addr_i),
        .funct3_i     (ids_funct3_i),
        .valid_o      (ex_valid),
        .jump_o       (ex_jump),
        .cond_o       (ex_cond),
        .link_o       (ex_link),
        .lq_wr_o      (ex_lq_wr),
        .sq_wr_o      (ex_sq_wr),
        .regd_wr_o    (ex_regd_wr),
        .pc_inc_o     (ex_pc_inc),
        .regs2_data_o (lsq_regs2_data_o),
        .regd_addr_o  (ex_regd_addr),
        .funct3_o     (ex_funct3)
    );

    //----------------------------------------------------------------------
    // alu, compare code is funct3
    //----------------------------------------------------------------------
    ex_alu #(
        .XLEN (XLEN)
    ) ex_alu_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .stage_en_i  (stage_en),
        .op_i        (ids_alu_op_i),
        .left_i      (ids_operand_left_i),
        .right_i     (ids_operand_right_i),
        .result_o    (alu_result),
        .cmp_op_i    (rv_isa_pkg::cmp_op_e'(ids_funct3_i)),
        .cmp_left_i  (ids_regs1_data_i),
        .cmp_right_i (ids_cmp_right_i),
        .cmp_o       (alu_cmp)
    );

    //----------------------------------------------------------------------
    // commit control
    //----------------------------------------------------------------------
    ex_commit_ctrl #(
        .XLEN        (XLEN),
        .TRAP_VECTOR (TRAP_VECTOR)
    ) ex_commit_ctrl_i (
        .valid_i      (ex_valid),
        .jump_i       (ex_jump),
        .cond_i       (ex_cond),
        .link_i       (ex_link),
        .lq_wr_i      (ex_lq_wr),
        .sq_wr_i      (ex_sq_wr),
        .regd_wr_i    (ex_regd_wr),
        .funct3_i     (ex_funct3),
        .pc_inc_i     (ex_pc_inc),
        .alu_result_i (alu_result),
        .cmp_i        (alu_cmp),
        .lsq_full_i   (lsq_full_i),
        .stage_en_o   (stage_en),
        .stall_o      (ids_stall_o),
        .regd_wr_o    (ids_regd_wr_o),
        .regd_data_o  (ids_regd_data_o),
        .jump_o       (pfu_jump_o),
        .jump_addr_o  (pfu_jump_addr_o),
        .lq_wr_o      (lsq_lq_wr_o),
        .sq_wr_o      (lsq_sq_wr_o),
        .trap_o       (trap_o),
        .trap_cause_o (trap_cause_o)
    );

endmodule

//--- testbench/ex_stage_checks.svh
/*
 * Compare tasks for words, flags and trap causes,
 * failure and timeout reporting
 */

`ifndef EX_STAGE_CHECKS_SVH
`define EX_STAGE_CHECKS_SVH

// print the reason, then stop the run
task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic report_timeout(input string what);
    fail_run({"timeout while waiting for ", what});
endtask

//----------------------------------------------------------------------
// compare tasks
//----------------------------------------------------------------------
task automatic check_word(input string test, input logic [XLEN-1:0] expected,
                          input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
        fail_run($sformatf("error: %s expected %h actual %h", test, expected, actual));
    end
endtask

task automatic check_flag(input string test, input logic expected, input logic actual);
    if (actual !== expected) begin
        fail_run($sformatf("error: %s expected %b actual %b", test, expected, actual));
    end
endtask

task automatic check_cause(input string test, input ex_stage_pkg::trap_cause_e expected,
                           input ex_stage_pkg::trap_cause_e actual);
    if (actual !== expected) begin
        fail_run($sformatf("error: %s expected %0d actual %0d", test, expected, actual));
    end
endtask

`endif

//--- testbench/tb_ex_stage.sv
/*
 * Testbench for the execute stage: clock, reset, vector file reading,
 * stimulus driving and result checks
 */

`timescale 1ns/1ns

module tb_ex_stage;

    localparam int              XLEN        = rv_isa_pkg::XLEN;
    localparam logic [XLEN-1:0] TRAP_VECTOR = 32'h0000_0100;
    localparam int              WAIT_LIMIT  = 64;

    logic                      clk_i = 1'b0;
    logic                      reset_i;
    logic                      ids_valid_i;
    logic                      ids_stall_o;
    logic [1:0]                ids_ins_size_i;
    logic                      ids_jump_i;
    logic                      ids_cond_i;
    logic                      ids_link_i;
    ex_stage_pkg::zone_e       ids_zone_i;
    logic [XLEN-1:0]           ids_pc_i;
    rv_isa_pkg::alu_op_e       ids_alu_op_i;
    logic [XLEN-1:0]           ids_operand_left_i;
    logic [XLEN-1:0]           ids_operand_right_i;
    logic [XLEN-1:0]           ids_regs1_data_i;
    logic [XLEN-1:0]           ids_cmp_right_i;
    logic [XLEN-1:0]           ids_regs2_data_i;
    logic [2:0]                ids_funct3_i;
    logic [4:0]                ids_regd_addr_i;
    logic                      ids_regd_wr_o;
    logic [4:0]                ids_regd_addr_o;
    logic [XLEN-1:0]           ids_regd_data_o;
    logic                      pfu_jump_o;
    logic [XLEN-1:0]           pfu_jump_addr_o;
    logic                      lsq_full_i;
    logic                      lsq_lq_wr_o;
    logic                      lsq_sq_wr_o;
    logic [2:0]                lsq_funct3_o;
    logic [4:0]                lsq_regd_addr_o;
    logic [XLEN-1:0]           lsq_regs2_data_o;
    logic [XLEN-1:0]           lsq_addr_o;
    logic                      trap_o;
    ex_stage_pkg::trap_cause_e trap_cause_o;

    // one variable per column of the vector file
    string           vec_name;
    string           exp_wb_s;
    string           exp_jump_s;
    string           exp_lsq_s;
    logic            v_jump;
    logic            v_cond;
    logic            v_link;
    logic [1:0]      v_zone;
    logic [1:0]      v_size;
    logic [3:0]      v_op;
    logic [2:0]      v_funct3;
    logic [XLEN-1:0] v_pc;
    logic [XLEN-1:0] v_left;
    logic [XLEN-1:0] v_right;
    logic [XLEN-1:0] v_rs1;
    logic [XLEN-1:0] v_cmpr;
    logic [XLEN-1:0] v_rs2;
    logic [4:0]      v_rd;
    int              v_hold;
    int              v_cause;
    int              seed = 32'h58ef_8f2a;

    `include "ex_stage_checks.svh"

    always #4 clk_i = ~clk_i;

    ex_stage #(
        .XLEN        (XLEN),
        .TRAP_VECTOR (TRAP_VECTOR)
    ) ex_stage_i (.*);

    //----------------------------------------------------------------------
    // helpers
    //----------------------------------------------------------------------
    task automatic init_inputs();
        reset_i             <= 1'b1;
        ids_valid_i         <= 1'b0;
        ids_ins_size_i      <= 2'd0;
        ids_jump_i          <= 1'b0;
        ids_cond_i          <= 1'b0;
        ids_link_i          <= 1'b0;
        ids_zone_i          <= ex_stage_pkg::ZONE_NONE;
        ids_pc_i            <= '0;
        ids_alu_op_i        <= rv_isa_pkg::ALU_ADD;
        ids_operand_left_i  <= '0;
        ids_operand_right_i <= '0;
        ids_regs1_data_i    <= '0;
        ids_cmp_right_i     <= '0;
        ids_regs2_data_i    <= '0;
        ids_funct3_i        <= 3'd0;
        ids_regd_addr_i     <= 5'd0;
        lsq_full_i          <= 1'b0;
    endtask

    // no strobe and no stall
    task automatic check_idle(input string test);
        check_flag({test, " stall"}, 1'b0, ids_stall_o);
        check_flag({test, " regd_wr"}, 1'b0, ids_regd_wr_o);
        check_flag({test, " jump"}, 1'b0, pfu_jump_o);
        check_flag({test, " lq_wr"}, 1'b0, lsq_lq_wr_o);
        check_flag({test, " sq_wr"}, 1'b0, lsq_sq_wr_o);
        check_flag({test, " trap"}, 1'b0, trap_o);
    endtask

    task automatic apply_reset();
        // valid jump with write-back offered while reset is high
        ids_valid_i <= 1'b1;
        ids_jump_i  <= 1'b1;
        ids_zone_i  <= ex_stage_pkg::ZONE_REGFILE;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk_i);
            if (i == 7) begin
                reset_i     <= 1'b0;
                ids_valid_i <= 1'b0;
                ids_jump_i  <= 1'b0;
                ids_zone_i  <= ex_stage_pkg::ZONE_NONE;
            end
            @(negedge clk_i);
            check_idle("reset");
        end
    endtask

    // skips comment lines
    // got is low at the end of the file
    task automatic read_vector(input int fd, output bit got);
        int code;
        int ch;
        got = 1'b0;
        code = $fscanf(fd, "%s", vec_name);
        while (code == 1 && vec_name.getc(0) == "#") begin
            ch = $fgetc(fd);
            // 10 is newline
            while (ch != 10 && ch != -1) begin
                ch = $fgetc(fd);
            end
            code = $fscanf(fd, "%s", vec_name);
        end
        if (code == 1) begin
            code = $fscanf(fd, "%d %d %d %d %d %d %h %h %h %h %h %h %h %d %d %s %s %s %d",
                           v_jump, v_cond, v_link, v_zone, v_size, v_op, v_funct3,
                           v_pc, v_left, v_right, v_rs1, v_cmpr, v_rs2, v_rd, v_hold,
                           exp_wb_s, exp_jump_s, exp_lsq_s, v_cause);
            if (code != 19) begin
                fail_run({"malformed line in the vector file at ", vec_name});
            end
            got = 1'b1;
        end
    endtask

    //----------------------------------------------------------------------
    // drive one instruction, hold the queue full, resolve and check
    //----------------------------------------------------------------------
    task automatic apply_vector();
        int                        hold;
        int                        waited;
        ex_stage_pkg::trap_cause_e exp_cause;
        exp_cause = ex_stage_pkg::trap_cause_e'(v_cause[3:0]);
        hold = v_hold;
        if (hold > 0) begin
            hold = hold + ($unsigned($random(seed)) % 3);
        end
        @(posedge clk_i);
        ids_valid_i         <= 1'b1;
        ids_jump_i          <= v_jump;
        ids_cond_i          <= v_cond;
        ids_link_i          <= v_link;
        ids_zone_i          <= ex_stage_pkg::zone_e'(v_zone);
        ids_ins_size_i      <= v_size;
        ids_alu_op_i        <= rv_isa_pkg::alu_op_e'(v_op);
        ids_funct3_i        <= v_funct3;
        ids_pc_i            <= v_pc;
        ids_operand_left_i  <= v_left;
        ids_operand_right_i <= v_right;
        ids_regs1_data_i    <= v_rs1;
        ids_cmp_right_i     <= v_cmpr;
        ids_regs2_data_i    <= v_rs2;
        ids_regd_addr_i     <= v_rd;
        // fields stay put until an edge with the stall low
        waited = 0;
        @(negedge clk_i);
        while (ids_stall_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout({vec_name, " capture"});
            end
            @(negedge clk_i);
        end
        @(posedge clk_i);
        ids_valid_i <= 1'b0;
        lsq_full_i  <= (hold > 0);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk_i);
            check_flag({vec_name, " stall on full queue"}, 1'b1, ids_stall_o);
            check_flag({vec_name, " lq_wr on full queue"}, 1'b0, lsq_lq_wr_o);
            check_flag({vec_name, " sq_wr on full queue"}, 1'b0, lsq_sq_wr_o);
            @(posedge clk_i);
            if (i == hold - 1) begin
                lsq_full_i <= 1'b0;
            end
        end
        waited = 0;
        @(negedge clk_i);
        while (ids_stall_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout({vec_name, " resolution"});
            end
            @(negedge clk_i);
        end
        // resolution cycle
        check_flag({vec_name, " regd_wr"}, exp_wb_s != "none", ids_regd_wr_o);
        if (exp_wb_s != "none") begin
            check_word({vec_name, " regd_data"}, XLEN'(exp_wb_s.atohex()), ids_regd_data_o);
            check_word({vec_name, " regd_addr"}, XLEN'(v_rd), XLEN'(ids_regd_addr_o));
        end
        check_flag({vec_name, " jump"}, exp_jump_s != "none", pfu_jump_o);
        if (exp_jump_s != "none") begin
            check_word({vec_name, " jump_addr"}, XLEN'(exp_jump_s.atohex()), pfu_jump_addr_o);
        end
        check_flag({vec_name, " lq_wr"}, exp_lsq_s == "load", lsq_lq_wr_o);
        check_flag({vec_name, " sq_wr"}, exp_lsq_s == "store", lsq_sq_wr_o);
        if (exp_lsq_s != "none") begin
            // memory vectors use add for the address
            check_word({vec_name, " lsq_addr"}, v_left + v_right, lsq_addr_o);
            check_word({vec_name, " lsq_funct3"}, XLEN'(v_funct3), XLEN'(lsq_funct3_o));
            check_word({vec_name, " lsq_regd_addr"}, XLEN'(v_rd), XLEN'(lsq_regd_addr_o));
            check_word({vec_name, " lsq_regs2_data"}, v_rs2, lsq_regs2_data_o);
        end
        check_flag({vec_name, " trap"}, exp_cause != ex_stage_pkg::CAUSE_NONE, trap_o);
        check_cause({vec_name, " trap_cause"}, exp_cause, trap_cause_o);
        // strobes must not repeat in the bubble after the instruction
        @(negedge clk_i);
        check_idle({vec_name, " bubble"});
    endtask

    initial begin
        int fd;
        int count;
        bit got;
        init_inputs();
        apply_reset();
        fd = $fopen("testbench/ex_stage_vectors.txt", "r");
        if (fd == 0) begin
            fail_run("could not open testbench/ex_stage_vectors.txt");
        end
        count = 0;
        read_vector(fd, got);
        while (got) begin
            apply_vector();
            count++;
            read_vector(fd, got);
        end
        $fclose(fd);
        if (count == 0) begin
            fail_run("the vector file holds no vectors");
        end else begin
            $display("%0d vectors applied", count);
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- testbench/ex_stage_vectors.txt
# name jump cond link zone size alu_op funct3 pc left right regs1 cmp_right regs2 rd hold
# then expected: write-back data, redirect address, queue strobe, trap cause (hex, or none)
alu_add     0 0 0 1 2 0  0 100  1234     f00d     0        0        0        5  0 10241    none none  15
alu_sub     0 0 0 1 2 1  0 104  10       20       0        0        0        6  0 fffffff0 none none  15
alu_sll     0 0 0 1 2 2  0 108  3        24       0        0        0        7  0 30       none none  15
alu_slt     0 0 0 1 2 3  0 10c  fffffffe 1        0        0        0        8  0 1        none none  15
alu_sltu    0 0 0 1 2 4  0 110  fffffffe 1        0        0        0        9  0 0        none none  15
alu_xor     0 0 0 1 2 5  0 114  a5a5a5a5 0ff00ff0 0        0        0        10 0 aa55aa55 none none  15
alu_srl     0 0 0 1 2 6  0 118  80000000 1f       0        0        0        11 0 1        none none  15
alu_sra     0 0 0 1 2 7  0 11c  80000000 4        0        0        0        12 0 f8000000 none none  15
alu_or      0 0 0 1 2 8  0 120  12340000 5678     0        0        0        13 0 12345678 none none  15
alu_and     0 0 0 1 2 9  0 124  ff00ff00 0f0f0f0f 0        0        0        14 0 0f000f00 none none  15
alu_pass    0 0 0 1 2 10 0 128  deadbeef 12000    0        0        0        15 0 12000    none none  15
beq_taken   1 1 0 0 2 0  0 200  200      40       55       55       0        0  0 none 240      none  15
beq_not     1 1 0 0 2 0  0 200  200      40       55       56       0        0  0 none none     none  15
bne_taken   1 1 0 0 2 0  1 300  300      ffffffe0 1        2        0        0  0 none 2e0      none  15
blt_taken   1 1 0 0 2 0  4 400  400      10       ffffffff 1        0        0  0 none 410      none  15
blt_not     1 1 0 0 2 0  4 400  400      10       1        ffffffff 0        0  0 none none     none  15
bge_taken   1 1 0 0 2 0  5 500  500      8        7        7        0        0  0 none 508      none  15
bltu_taken  1 1 0 0 2 0  6 600  600      4        1        ffffffff 0        0  0 none 604      none  15
bgeu_not    1 1 0 0 2 0  7 600  600      4        1        ffffffff 0        0  0 none none     none  15
bne_not_mis 1 1 0 0 2 0  1 700  700      2        3        3        0        0  0 none none     none  15
jal         1 0 1 1 2 0  0 1000 1000     100      0        0        0        1  0 1004 1100     none  15
jalr        1 0 1 1 2 0  0 3000 2001     4        0        0        0        1  0 3004 2004     none  15
jal_c       1 0 1 1 1 0  0 4000 4000     20       0        0        0        1  0 4002 4020     none  15
lw          0 0 0 2 2 0  2 800  8000     10       0        0        0        3  0 none none     load  15
lh_full     0 0 0 2 2 0  1 804  8000     22       0        0        0        4  3 none none     load  15
lbu         0 0 0 2 2 0  4 808  8000     3        0        0        0        5  0 none none     load  15
sw_full     0 0 0 3 2 0  2 80c  9000     8        0        0        cafef00d 0  2 none none     store 15
sh          0 0 0 3 2 0  1 810  9000     2        0        0        1234     0  0 none none     store 15
sb_full     0 0 0 3 2 0  0 814  9000     1        0        0        ab       0  1 none none     store 15
lw_mis      0 0 0 2 2 0  2 818  8000     2        0        0        0        3  0 none 100      none  4
lhu_mis     0 0 0 2 2 0  5 81c  8000     1        0        0        0        3  0 none 100      none  4
sw_mis      0 0 0 3 2 0  2 820  9000     1        0        0        77       0  0 none 100      none  6
sh_mis      0 0 0 3 2 0  1 824  9000     3        0        0        77       0  0 none 100      none  6
jal_mis     1 0 1 1 2 0  0 5000 5000     6        0        0        0        1  0 none 100      none  0
beq_mis     1 1 0 0 2 0  0 600  600      2        9        9        0        0  0 none 100      none  0

//--- vlog.f
+incdir+testbench
verilog/rv_isa_pkg.sv
verilog/ex_stage_pkg.sv
verilog/ex_operand_reg.sv
verilog/ex_alu.sv
verilog/ex_commit_ctrl.sv
verilog/ex_stage.sv
testbench/tb_ex_stage.sv

//--- run_verilator.sh
#!/bin/sh
# build the execute stage testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ns -f vlog.f --top-module tb_ex_stage \
    -o tb_ex_stage &&
./obj_dir/tb_ex_stage | tee /dev/stderr | grep "Done: no errors" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
